/* logic/i3c_bus_pkg.sv */
// ----------------------------------------------------------
// I3C bus definitions
// Address and byte widths, broadcast address and the
// header/data view of a bus byte
// ----------------------------------------------------------

package i3c_bus_pkg;

  // Target address and bus byte widths
  localparam int unsigned AddrWidth = 7;
  localparam int unsigned ByteWidth = 8;

  // Broadcast address, only valid as a write header
  localparam logic [AddrWidth-1:0] BroadcastAddr = 7'h7E;

  // Header view of a byte
  // Address in the upper bits and the read/write flag in bit 0
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 rnw;
  } i3c_hdr_t;

  // One bus byte, read as a header or as plain data
  // Data covers write data, read data and CCC codes
  typedef union packed {
    i3c_hdr_t             hdr;
    logic [ByteWidth-1:0] data;
  } i3c_byte_u;

endpackage

/* logic/i3c_target_pkg.sv */
// ----------------------------------------------------------
// I3C target definitions
// Primary FSM states, ACK value and T-bit parity seed
// ----------------------------------------------------------

package i3c_target_pkg;

  // Primary FSM states
  typedef enum logic [3:0] {
    Idle,
    RxFByte,
    CheckFByte,
    TxAckFByte,
    RxSByte,
    RxSByteRepeated,
    CheckSByte,
    TxAckSByte,
    RxPWriteData,
    RxPWriteTbit,
    TxPReadData,
    TxPReadTbit,
    Wait
  } target_state_e;

  // SDA held low on the ninth bit
  localparam logic AckValue = 1'b0;

  // Odd parity, T-bit is XOR of the data bits and this seed
  localparam logic ParitySeed = 1'b1;

endpackage

/* logic/i3c_addr_decoder.sv */
// ----------------------------------------------------------
// I3C target address decoder
// Holds the last received header and matches it against the
// own address and the broadcast write header
// ----------------------------------------------------------

`timescale 1ns/1ps

module i3c_addr_decoder (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              hdr_capture_i,
  input  i3c_bus_pkg::i3c_byte_u            hdr_i,
  input  logic                              idle_i,
  input  logic [i3c_bus_pkg::AddrWidth-1:0] sta_addr_i,
  input  logic                              sta_addr_valid_i,
  input  logic [i3c_bus_pkg::AddrWidth-1:0] dyn_addr_i,
  input  logic                              dyn_addr_valid_i,
  output logic                              our_match_o,
  output logic                              bcast_match_o,
  output logic                              rnw_o,
  output i3c_bus_pkg::i3c_byte_u            last_addr_o
);
  import i3c_bus_pkg::*;

  i3c_byte_u            hdr_q;
  logic [AddrWidth-1:0] own_addr;
  logic                 own_valid;

  // Header register, cleared between transactions
  always_ff @(posedge clk_i or negedge rst_ni) begin : hdr_reg
    if (!rst_ni) begin
      hdr_q <= '0;
    end else if (hdr_capture_i) begin
      hdr_q <= hdr_i;
    end else if (idle_i) begin
      hdr_q <= '0;
    end
  end

  // Dynamic address wins when both are valid
  assign own_addr  = dyn_addr_valid_i ? dyn_addr_i : sta_addr_i;
  assign own_valid = dyn_addr_valid_i | sta_addr_valid_i;

  // Own match ignores rnw, the FSM decides on read or write
  assign our_match_o   = own_valid & (hdr_q.hdr.addr == own_addr);
  // Broadcast only as a write header
  assign bcast_match_o = (hdr_q.hdr.addr == BroadcastAddr) & ~hdr_q.hdr.rnw;
  assign rnw_o         = hdr_q.hdr.rnw;
  assign last_addr_o   = hdr_q;

  // Own and broadcast match are exclusive unless own address is 7'h7E
  match_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (own_valid && own_addr != BroadcastAddr) |-> !(our_match_o && bcast_match_o));

endmodule

/* logic/i3c_rx_data_path.sv */
// ----------------------------------------------------------
// I3C private write data path
// Captures data bytes, checks the odd-parity T-bit and
// writes good bytes to the RX FIFO
// ----------------------------------------------------------

`timescale 1ns/1ps

module i3c_rx_data_path (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              wr_byte_done_i,
  input  logic                              wr_tbit_done_i,
  input  i3c_bus_pkg::i3c_byte_u            rx_data_i,
  input  logic                              rx_tbit_i,
  input  logic                              rx_fifo_wready_i,
  output logic                              rx_fifo_wvalid_o,
  output logic [i3c_bus_pkg::ByteWidth-1:0] rx_fifo_wdata_o,
  output logic                              parity_err_o,
  output logic                              rx_overflow_err_o
);
  import i3c_bus_pkg::*;
  import i3c_target_pkg::*;

  i3c_byte_u byte_q;
  logic      ovf_q;
  logic      parity_ok;

  // Last received data byte
  always_ff @(posedge clk_i) begin : byte_reg
    if (wr_byte_done_i) begin
      byte_q <= rx_data_i;
    end
  end

  // Expected T-bit from the held byte
  assign parity_ok = (rx_tbit_i == (^byte_q.data ^ ParitySeed));

  always_ff @(posedge clk_i or negedge rst_ni) begin : status_reg
    if (!rst_ni) begin
      ovf_q             <= 1'b0;
      rx_overflow_err_o <= 1'b0;
      rx_fifo_wvalid_o  <= 1'b0;
      parity_err_o      <= 1'b0;
    end else begin
      // FIFO full when the byte lands, so this byte is dropped
      if (wr_byte_done_i) begin
        ovf_q <= ~rx_fifo_wready_i;
      end
      rx_overflow_err_o <= wr_byte_done_i & ~rx_fifo_wready_i;
      // Outcome of the T-bit, one cycle later
      rx_fifo_wvalid_o  <= wr_tbit_done_i & parity_ok & ~ovf_q;
      parity_err_o      <= wr_tbit_done_i & ~parity_ok;
    end
  end

  assign rx_fifo_wdata_o = byte_q.data;

  // A byte is either written or flagged, never both
  wr_or_err_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rx_fifo_wvalid_o && parity_err_o));

endmodule

/* logic/i3c_tx_data_path.sv */
// ----------------------------------------------------------
// I3C private read data path
// Holds the byte fetched from the TX FIFO and its last flag
// ----------------------------------------------------------

`timescale 1ns/1ps

module i3c_tx_data_path (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              rd_fetch_i,
  input  logic [i3c_bus_pkg::ByteWidth-1:0] tx_fifo_rdata_i,
  input  logic                              tx_last_byte_i,
  output logic [i3c_bus_pkg::ByteWidth-1:0] rd_byte_o,
  output logic                              rd_more_o
);
  import i3c_bus_pkg::*;

  logic [ByteWidth-1:0] byte_q;
  logic                 last_q;

  // Byte stays put through data and T-bit phases
  always_ff @(posedge clk_i) begin : byte_reg
    if (rd_fetch_i) begin
      byte_q <= tx_fifo_rdata_i;
    end
  end

  // No data pending after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin : last_reg
    if (!rst_ni) begin
      last_q <= 1'b1;
    end else if (rd_fetch_i) begin
      last_q <= tx_last_byte_i;
    end
  end

  assign rd_byte_o = byte_q;
  // T-bit high while more data follows
  assign rd_more_o = ~last_q;

endmodule

/* logic/i3c_target_fsm.sv */
// ----------------------------------------------------------
// I3C target primary FSM
// Header handling, private read/write loops, CCC latch and
// status events, with request/done toward the bus engine
// ----------------------------------------------------------

`timescale 1ns/1ps

module i3c_target_fsm (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              target_enable_i,
  input  logic                              bus_start_det_i,
  input  logic                              bus_stop_det_i,
  input  logic                              bus_rx_done_i,
  input  i3c_bus_pkg::i3c_byte_u            bus_rx_data_i,
  input  logic                              bus_tx_done_i,
  input  logic                              our_match_i,
  input  logic                              bcast_match_i,
  input  logic                              rnw_i,
  input  logic [i3c_bus_pkg::ByteWidth-1:0] rd_byte_i,
  input  logic                              rd_more_i,
  input  logic                              tx_fifo_rvalid_i,
  output logic                              bus_rx_req_byte_o,
  output logic                              bus_rx_req_bit_o,
  output logic                              bus_tx_req_byte_o,
  output logic                              bus_tx_req_bit_o,
  output logic [i3c_bus_pkg::ByteWidth-1:0] bus_tx_value_o,
  output logic                              hdr_capture_o,
  output logic                              wr_byte_done_o,
  output logic                              wr_tbit_done_o,
  output logic                              rd_fetch_o,
  output logic [i3c_bus_pkg::ByteWidth-1:0] ccc_o,
  output logic                              ccc_valid_o,
  output logic                              event_target_nack_o,
  output logic                              target_idle_o,
  output logic                              target_transmitting_o
);
  import i3c_bus_pkg::*;
  import i3c_target_pkg::*;

  target_state_e state_q, state_d;
  logic          rx_done;
  logic          hdr_accept;
  logic          ccc_strobe;
  logic          nack_d;

  // RX requests are dropped on START, so no done counts then
  assign rx_done    = bus_rx_done_i & ~bus_start_det_i;
  // Reads only with data waiting in the TX FIFO
  assign hdr_accept = our_match_i & (~rnw_i | tx_fifo_rvalid_i);
  // Byte after the broadcast header is the CCC code
  assign ccc_strobe = (state_q == RxSByte) & rx_done;

  always_comb begin : state_outputs
    bus_rx_req_byte_o = 1'b0;
    bus_rx_req_bit_o  = 1'b0;
    bus_tx_req_byte_o = 1'b0;
    bus_tx_req_bit_o  = 1'b0;
    bus_tx_value_o    = '0;
    hdr_capture_o     = 1'b0;
    wr_byte_done_o    = 1'b0;
    wr_tbit_done_o    = 1'b0;
    case (state_q)
      // Header candidates, also the CCC byte in RxSByte
      RxFByte, RxSByte, RxSByteRepeated: begin
        bus_rx_req_byte_o = ~bus_start_det_i;
        hdr_capture_o     = rx_done;
      end
      TxAckFByte, TxAckSByte: begin
        bus_tx_req_bit_o = 1'b1;
        bus_tx_value_o   = {{(ByteWidth-1){1'b0}}, AckValue};
      end
      RxPWriteData: begin
        bus_rx_req_byte_o = ~bus_start_det_i;
        wr_byte_done_o    = rx_done;
      end
      RxPWriteTbit: begin
        bus_rx_req_bit_o = ~bus_start_det_i;
        wr_tbit_done_o   = rx_done;
      end
      TxPReadData: begin
        bus_tx_req_byte_o = 1'b1;
        bus_tx_value_o    = rd_byte_i;
      end
      TxPReadTbit: begin
        bus_tx_req_bit_o = 1'b1;
        bus_tx_value_o   = {{(ByteWidth-1){1'b0}}, rd_more_i};
      end
      default: ;
    endcase
  end

  always_comb begin : state_next
    state_d = state_q;
    nack_d  = 1'b0;
    case (state_q)
      Idle: if (target_enable_i && bus_start_det_i) state_d = RxFByte;
      RxFByte: if (rx_done) state_d = CheckFByte;
      CheckFByte: begin
        if (bcast_match_i || hdr_accept) begin
          state_d = TxAckFByte;
        end else begin
          state_d = Wait;
          nack_d  = 1'b1;
        end
      end
      TxAckFByte: begin
        if (bus_tx_done_i) begin
          state_d = bcast_match_i ? RxSByte : (rnw_i ? TxPReadData : RxPWriteData);
        end
      end
      // Repeated START means a directed header follows
      RxSByte: begin
        if (bus_start_det_i) state_d = RxSByteRepeated;
        else if (rx_done) state_d = Wait;
      end
      RxSByteRepeated: if (rx_done) state_d = CheckSByte;
      CheckSByte: begin
        if (hdr_accept) begin
          state_d = TxAckSByte;
        end else begin
          state_d = Wait;
          nack_d  = 1'b1;
        end
      end
      TxAckSByte: if (bus_tx_done_i) state_d = rnw_i ? TxPReadData : RxPWriteData;
      RxPWriteData: begin
        if (bus_start_det_i) state_d = RxFByte;
        else if (rx_done) state_d = RxPWriteTbit;
      end
      RxPWriteTbit: begin
        if (bus_start_det_i) state_d = RxFByte;
        else if (rx_done) state_d = RxPWriteData;
      end
      TxPReadData: begin
        if (bus_start_det_i) state_d = RxFByte;
        else if (bus_tx_done_i) state_d = TxPReadTbit;
      end
      // Next byte while the T-bit said more data
      TxPReadTbit: begin
        if (bus_start_det_i) state_d = RxFByte;
        else if (bus_tx_done_i) state_d = rd_more_i ? TxPReadData : Wait;
      end
      Wait: if (bus_start_det_i) state_d = RxFByte;
      default: state_d = Idle;
    endcase
    // STOP ends everything
    if (bus_stop_det_i) state_d = Idle;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      state_q             <= Idle;
      ccc_o               <= '0;
      ccc_valid_o         <= 1'b0;
      event_target_nack_o <= 1'b0;
    end else begin
      state_q             <= state_d;
      ccc_valid_o         <= ccc_strobe;
      event_target_nack_o <= nack_d;
      if (ccc_strobe) begin
        ccc_o <= bus_rx_data_i.data;
      end
    end
  end

  // Pop the TX FIFO on entry to the data phase
  assign rd_fetch_o = (state_d == TxPReadData) & (state_q != TxPReadData);

  assign target_idle_o         = (state_q == Idle);
  assign target_transmitting_o = state_q inside {TxAckFByte, TxAckSByte,
                                                 TxPReadData, TxPReadTbit};

  // One transfer at a time toward the bus engine
  req_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({bus_rx_req_byte_o, bus_rx_req_bit_o, bus_tx_req_byte_o, bus_tx_req_bit_o}));

  // Nothing requested while idle
  idle_quiet_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    target_idle_o |-> !(bus_rx_req_byte_o || bus_rx_req_bit_o ||
                        bus_tx_req_byte_o || bus_tx_req_bit_o));

endmodule

/* logic/i3c_target.sv */
// ----------------------------------------------------------
// I3C target top level
// Address decoder, RX/TX data paths and primary FSM
// ----------------------------------------------------------

`timescale 1ns/1ps

module i3c_target (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              target_enable_i,
  input  logic                              bus_start_det_i,
  input  logic                              bus_stop_det_i,
  input  logic                              bus_rx_done_i,
  input  i3c_bus_pkg::i3c_byte_u            bus_rx_data_i,
  input  logic                              bus_tx_done_i,
  output logic                              bus_rx_req_byte_o,
  output logic                              bus_rx_req_bit_o,
  output logic                              bus_tx_req_byte_o,
  output logic                              bus_tx_req_bit_o,
  output logic [i3c_bus_pkg::ByteWidth-1:0] bus_tx_value_o,
  input  logic [i3c_bus_pkg::AddrWidth-1:0] sta_addr_i,
  input  logic                              sta_addr_valid_i,
  input  logic [i3c_bus_pkg::AddrWidth-1:0] dyn_addr_i,
  input  logic                              dyn_addr_valid_i,
  output i3c_bus_pkg::i3c_byte_u            last_addr_o,
  input  logic                              rx_fifo_wready_i,
  output logic                              rx_fifo_wvalid_o,
  output logic [i3c_bus_pkg::ByteWidth-1:0] rx_fifo_wdata_o,
  output logic                              parity_err_o,
  output logic                              rx_overflow_err_o,
  input  logic                              tx_fifo_rvalid_i,
  output logic                              tx_fifo_rready_o,
  input  logic [i3c_bus_pkg::ByteWidth-1:0] tx_fifo_rdata_i,
  input  logic                              tx_last_byte_i,
  output logic [i3c_bus_pkg::ByteWidth-1:0] ccc_o,
  output logic                              ccc_valid_o,
  output logic                              event_target_nack_o,
  output logic                              target_idle_o,
  output logic                              target_transmitting_o
);
  import i3c_bus_pkg::*;

  logic                 our_match;
  logic                 bcast_match;
  logic                 rnw;
  logic                 hdr_capture;
  logic                 wr_byte_done;
  logic                 wr_tbit_done;
  logic                 rd_fetch;
  logic [ByteWidth-1:0] rd_byte;
  logic                 rd_more;

  // Fetch strobe doubles as the TX FIFO pop
  assign tx_fifo_rready_o = rd_fetch;

  // Header register clears while the FSM is idle
  i3c_addr_decoder u_addr_decoder (
    .clk_i, .rst_ni,
    .hdr_capture_i(hdr_capture), .hdr_i(bus_rx_data_i), .idle_i(target_idle_o),
    .sta_addr_i, .sta_addr_valid_i, .dyn_addr_i, .dyn_addr_valid_i,
    .our_match_o(our_match), .bcast_match_o(bcast_match), .rnw_o(rnw),
    .last_addr_o
  );

  // T-bit arrives in bit 0 of the RX data
  i3c_rx_data_path u_rx_data_path (
    .clk_i, .rst_ni,
    .wr_byte_done_i(wr_byte_done), .wr_tbit_done_i(wr_tbit_done),
    .rx_data_i(bus_rx_data_i), .rx_tbit_i(bus_rx_data_i.data[0]),
    .rx_fifo_wready_i, .rx_fifo_wvalid_o, .rx_fifo_wdata_o,
    .parity_err_o, .rx_overflow_err_o
  );

  i3c_tx_data_path u_tx_data_path (
    .clk_i, .rst_ni,
    .rd_fetch_i(rd_fetch), .tx_fifo_rdata_i, .tx_last_byte_i,
    .rd_byte_o(rd_byte), .rd_more_o(rd_more)
  );

  i3c_target_fsm u_target_fsm (
    .clk_i, .rst_ni, .target_enable_i,
    .bus_start_det_i, .bus_stop_det_i,
    .bus_rx_done_i, .bus_rx_data_i, .bus_tx_done_i,
    .our_match_i(our_match), .bcast_match_i(bcast_match), .rnw_i(rnw),
    .rd_byte_i(rd_byte), .rd_more_i(rd_more), .tx_fifo_rvalid_i,
    .bus_rx_req_byte_o, .bus_rx_req_bit_o, .bus_tx_req_byte_o, .bus_tx_req_bit_o,
    .bus_tx_value_o,
    .hdr_capture_o(hdr_capture), .wr_byte_done_o(wr_byte_done),
    .wr_tbit_done_o(wr_tbit_done), .rd_fetch_o(rd_fetch),
    .ccc_o, .ccc_valid_o, .event_target_nack_o,
    .target_idle_o, .target_transmitting_o
  );

endmodule

/* testbench/i3c_target_tb.sv */
// ----------------------------------------------------------
// I3C target testbench
// Bus engine and FIFO models, transaction table and checks
// ----------------------------------------------------------

`timescale 1ns/1ps

module i3c_target_tb;
  import i3c_bus_pkg::*;

  localparam int ModeWr = 0;
  localparam int ModeRd = 1;
  localparam int ModeNack = 2;
  localparam int ModeCcc = 3;
  localparam int ModeBcWr = 4;
  localparam int NumRows = 8;

  typedef struct {
    string                name;
    int                   mode;
    i3c_byte_u            hdr;
    i3c_byte_u            hdr2;
    logic [2:0][7:0]      data;
    int                   n;
    int                   bad;
    int                   ovf;
    logic                 dyn_v;
  } row_t;

  logic clk_i = 1'b0;
  logic rst_ni, target_enable_i, bus_start_det_i, bus_stop_det_i;
  logic bus_rx_done_i, bus_tx_done_i;
  i3c_byte_u bus_rx_data_i;
  logic bus_rx_req_byte_o, bus_rx_req_bit_o, bus_tx_req_byte_o, bus_tx_req_bit_o;
  logic [7:0] bus_tx_value_o;
  logic [AddrWidth-1:0] sta_addr_i, dyn_addr_i;
  logic sta_addr_valid_i, dyn_addr_valid_i;
  i3c_byte_u last_addr_o;
  logic rx_fifo_wready_i, rx_fifo_wvalid_o, parity_err_o, rx_overflow_err_o;
  logic [7:0] rx_fifo_wdata_o, tx_fifo_rdata_i, ccc_o;
  logic tx_fifo_rvalid_i, tx_fifo_rready_o, tx_last_byte_i;
  logic ccc_valid_o, event_target_nack_o, target_idle_o, target_transmitting_o;

  row_t rows [NumRows];
  logic [7:0] wr_q [$];
  logic [7:0] exp_q [$];
  logic [2:0][7:0] tx_mem;
  int tx_idx, tx_cnt;
  int parity_cnt, ovf_cnt, nack_cnt, ccc_cnt, tx_req_cycles;
  logic tx_pop_seen;

  i3c_target UUT (.*);

  always #20 clk_i = ~clk_i;

  // Monitor, sampled mid-cycle where outputs are stable
  always @(negedge clk_i) begin
    tx_pop_seen <= rst_ni & tx_fifo_rready_o;
    if (rst_ni) begin
      if (rx_fifo_wvalid_o) wr_q.push_back(rx_fifo_wdata_o);
      if (parity_err_o) parity_cnt++;
      if (rx_overflow_err_o) ovf_cnt++;
      if (event_target_nack_o) nack_cnt++;
      if (ccc_valid_o) ccc_cnt++;
      if (bus_tx_req_byte_o || bus_tx_req_bit_o) tx_req_cycles++;
    end
  end

  // TX FIFO model, head advances after each pop
  always @(posedge clk_i) begin
    if (tx_pop_seen) tx_idx = tx_idx + 1;
    tx_fifo_rvalid_i <= (tx_idx < tx_cnt);
    tx_fifo_rdata_i  <= (tx_idx < 3) ? tx_mem[tx_idx] : 8'h00;
    tx_last_byte_i   <= (tx_idx == tx_cnt - 1);
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_byte(input string name, input i3c_byte_u exp, input i3c_byte_u act);
    if (exp !== act) begin
      fail_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      fail_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      fail_run($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  // Engine answers a request after 1 to 4 cycles
  task automatic rx_xfer(input string name, input logic [7:0] value, input logic is_bit);
    int t;
    int lat;
    t = 0;
    @(negedge clk_i);
    while (!(bus_rx_req_byte_o || bus_rx_req_bit_o)) begin
      t++;
      if (t > 50) fail_run({name, ": no RX request from the target in time"});
      @(negedge clk_i);
    end
    check_bit({name, " rx bit request"}, is_bit, bus_rx_req_bit_o);
    check_bit({name, " transmitting during rx"}, 1'b0, target_transmitting_o);
    lat = 1 + ($urandom % 4);
    repeat (lat - 1) @(posedge clk_i);
    @(posedge clk_i);
    bus_rx_done_i <= 1'b1;
    bus_rx_data_i <= value;
    @(posedge clk_i);
    bus_rx_done_i <= 1'b0;
  endtask

  task automatic tx_xfer(input string name, input logic is_bit, output logic [7:0] value);
    int t;
    int lat;
    t = 0;
    @(negedge clk_i);
    while (!(bus_tx_req_byte_o || bus_tx_req_bit_o)) begin
      t++;
      if (t > 50) fail_run({name, ": no TX request from the target in time"});
      @(negedge clk_i);
    end
    check_bit({name, " tx bit request"}, is_bit, bus_tx_req_bit_o);
    check_bit({name, " transmitting during tx"}, 1'b1, target_transmitting_o);
    value = bus_tx_value_o;
    lat = 1 + ($urandom % 4);
    repeat (lat - 1) @(posedge clk_i);
    @(posedge clk_i);
    bus_tx_done_i <= 1'b1;
    @(posedge clk_i);
    bus_tx_done_i <= 1'b0;
  endtask

  task automatic pulse_line(input logic is_stop);
    @(posedge clk_i);
    if (is_stop) bus_stop_det_i <= 1'b1;
    else bus_start_det_i <= 1'b1;
    @(posedge clk_i);
    bus_stop_det_i  <= 1'b0;
    bus_start_det_i <= 1'b0;
  endtask

  task automatic wait_idle(input string name);
    int t;
    t = 0;
    @(negedge clk_i);
    while (!target_idle_o) begin
      t++;
      if (t > 20) fail_run({name, ": target did not return to idle after STOP"});
      @(negedge clk_i);
    end
  endtask

  // Private write data bytes, each with an odd-parity T-bit
  task automatic write_bytes(input row_t r);
    logic tbit;
    for (int j = 0; j < r.n; j++) begin
      @(posedge clk_i);
      rx_fifo_wready_i <= (j != r.ovf);
      tbit = ^r.data[j] ^ 1'b1;
      if (j == r.bad) tbit = ~tbit;
      rx_xfer(r.name, r.data[j], 1'b0);
      rx_xfer(r.name, {7'b0, tbit}, 1'b1);
      if (j != r.bad && j != r.ovf) exp_q.push_back(r.data[j]);
    end
    @(posedge clk_i);
    rx_fifo_wready_i <= 1'b1;
  endtask

  initial begin
    row_t r;
    logic [7:0] v;
    rows[0] = '{"wr_dyn", ModeWr, 8'h54, 8'h00, {8'h33, 8'h22, 8'h11}, 3, -1, -1, 1'b1};
    rows[1] = '{"wr_bad_parity", ModeWr, 8'h54, 8'h00, {8'hC3, 8'h5A, 8'h01}, 3, 1, -1, 1'b1};
    rows[2] = '{"rd_sta", ModeRd, 8'h6B, 8'h00, {8'hC3, 8'hB2, 8'hA1}, 3, -1, -1, 1'b0};
    rows[3] = '{"nack_addr", ModeNack, 8'h20, 8'h00, '0, 0, -1, -1, 1'b1};
    rows[4] = '{"nack_rd_empty", ModeNack, 8'h55, 8'h00, '0, 0, -1, -1, 1'b1};
    rows[5] = '{"ccc", ModeCcc, 8'hFC, 8'h00, {8'h00, 8'h00, 8'h07}, 1, -1, -1, 1'b1};
    rows[6] = '{"bcast_then_wr", ModeBcWr, 8'hFC, 8'h54, {8'h9F, 8'h80, 8'h7E}, 3, -1, -1, 1'b1};
    rows[7] = '{"wr_overflow", ModeWr, 8'h54, 8'h00, {8'h44, 8'h0F, 8'hF0}, 3, -1, 1, 1'b1};
    void'($urandom(32'h9ace232e));
    tx_idx = 0;
    tx_cnt = 0;
    tx_mem = '0;
    rst_ni = 1'b0;
    target_enable_i = 1'b1;
    bus_start_det_i = 1'b0;
    bus_stop_det_i = 1'b0;
    bus_rx_done_i = 1'b0;
    bus_tx_done_i = 1'b0;
    bus_rx_data_i = '0;
    sta_addr_i = 7'h35;
    sta_addr_valid_i = 1'b1;
    dyn_addr_i = 7'h2A;
    dyn_addr_valid_i = 1'b1;
    rx_fifo_wready_i = 1'b1;
    tx_fifo_rvalid_i = 1'b0;
    tx_fifo_rdata_i = '0;
    tx_last_byte_i = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < NumRows; i++) begin
      r = rows[i];
      @(negedge clk_i);
      tx_mem = r.data;
      tx_cnt = (r.mode == ModeRd) ? r.n : 0;
      tx_idx = 0;
      {parity_cnt, ovf_cnt, nack_cnt, ccc_cnt, tx_req_cycles} = '0;
      wr_q.delete();
      exp_q.delete();
      @(posedge clk_i);
      dyn_addr_valid_i <= r.dyn_v;
      repeat (2) @(posedge clk_i);
      pulse_line(1'b0);
      rx_xfer(r.name, r.hdr.data, 1'b0);
      if (r.mode == ModeNack) begin
        repeat (6) @(negedge clk_i);
        check_count({r.name, " ack requests"}, 0, tx_req_cycles);
      end else begin
        tx_xfer(r.name, 1'b1, v);
        check_bit({r.name, " ack"}, 1'b0, v[0]);
        if (r.mode == ModeCcc) rx_xfer(r.name, r.data[0], 1'b0);
        if (r.mode == ModeBcWr) begin
          pulse_line(1'b0);
          rx_xfer(r.name, r.hdr2.data, 1'b0);
          tx_xfer(r.name, 1'b1, v);
          check_bit({r.name, " second ack"}, 1'b0, v[0]);
        end
        if (r.mode == ModeWr || r.mode == ModeBcWr) begin
          @(negedge clk_i);
          check_byte({r.name, " last_addr"}, (r.mode == ModeWr) ? r.hdr : r.hdr2, last_addr_o);
          write_bytes(r);
        end
        if (r.mode == ModeRd) begin
          for (int j = 0; j < r.n; j++) begin
            tx_xfer(r.name, 1'b0, v);
            check_byte({r.name, " read byte"}, r.data[j], v);
            tx_xfer(r.name, 1'b1, v);
            check_bit({r.name, " T-bit"}, (j < r.n - 1), v[0]);
          end
          tx_req_cycles = 0;
          repeat (6) @(negedge clk_i);
          check_count({r.name, " requests after last byte"}, 0, tx_req_cycles);
        end
      end
      pulse_line(1'b1);
      wait_idle(r.name);
      check_count({r.name, " nack pulses"}, (r.mode == ModeNack), nack_cnt);
      check_count({r.name, " parity errors"}, (r.bad >= 0), parity_cnt);
      check_count({r.name, " overflow errors"}, (r.ovf >= 0), ovf_cnt);
      check_count({r.name, " fifo writes"}, exp_q.size(), wr_q.size());
      foreach (exp_q[k]) check_byte({r.name, " fifo data"}, exp_q[k], wr_q[k]);
      check_count({r.name, " ccc strobes"}, (r.mode == ModeCcc), ccc_cnt);
      if (r.mode == ModeCcc) begin
        check_byte({r.name, " ccc code"}, r.data[0], ccc_o);
      end
    end
    $display("Verification passed");
    $finish;
  end

endmodule

/* compile.f */
logic/i3c_bus_pkg.sv
logic/i3c_target_pkg.sv
logic/i3c_addr_decoder.sv
logic/i3c_rx_data_path.sv
logic/i3c_tx_data_path.sv
logic/i3c_target_fsm.sv
logic/i3c_target.sv
testbench/i3c_target_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the I3C target testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
  --top-module i3c_target_tb -Mdir obj_dir -o i3c_sim \
  && (./obj_dir/i3c_sim > sim.log 2>&1; cat sim.log) \
  || { echo "Build or run error"; exit 1; }

grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
